/* design/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_WORD_WIDTH 8

// Special encodings
// NOP doubles as the opcode reset value
`define CPU_NOP_BYTE   8'hFE
`define CPU_HLT_BYTE   8'hFF
`define CPU_JMP_PREFIX 4'b1100

// Opcode byte fields
`define CPU_JMP_BITS   7:4
`define CPU_GROUP_BITS 7:6
`define CPU_OP_BITS    5:4
`define CPU_DST_BITS   3:2
`define CPU_SRC_BITS   1:0

`define CPU_GROUP_A_A   2'b00
`define CPU_GROUP_SP_SP 2'b01
`define CPU_GROUP_SP_A  2'b10

`define CPU_OP_MOV 2'b00
`define CPU_OP_ADD 2'b01

// Operand modes
// Immediate is a source mode only
`define CPU_MODE_REG 2'b00
`define CPU_MODE_MEM 2'b10
`define CPU_MODE_IMM 2'b11

`endif

/* design/cpu_pkg.sv */
package cpu_pkg;

  typedef enum logic [2:0] {
    RESET_STAGE,
    FETCH_OPERATION,
    DECODE,
    FETCH_OPERAND,
    EXECUTE,
    WRITE_REGISTER,
    WRITE_MEMORY,
    HALTED
  } cpu_stage_t;

  // Opcode byte fetch
  typedef enum logic [1:0] {IDLE, REQUEST, LOAD} fetch_phase_t;

  // Operand bytes as a WAIT cycle followed by a LOAD cycle
  typedef enum logic [3:0] {
    BEGIN,
    WAIT_IMM, LOAD_IMM,
    WAIT_SRC_ADDR, LOAD_SRC_ADDR,
    WAIT_SRC, LOAD_SRC,
    WAIT_DST_ADDR, LOAD_DST_ADDR,
    WAIT_DST, LOAD_DST,
    DONE
  } operand_phase_t;

  typedef enum logic [2:0] {MOV, ADD, JMP, NOP, HLT} opcode_t;

  typedef enum logic [2:0] {UNUSED, REG_A, REG_SP, ADDRESS_IMM, IMM} operand_t;

  typedef enum logic [1:0] {MEMORY_STAY, MEMORY_READ, MEMORY_WRITE} mem_cmd_t;

endpackage

/* design/stage_control.sv */
`timescale 1ns/1ps

module stage_control (
  input    logic                CLOCK
  , input  logic                RESET
  , input  logic                fetch_done
  , input  logic                operand_done
  , input  cpu_pkg::opcode_t    decode_ope
  , input  cpu_pkg::operand_t   decode_dst
  , output cpu_pkg::cpu_stage_t stage
);
  import cpu_pkg::*;

  cpu_stage_t next_stage;

  always_comb begin
    case (stage)
      RESET_STAGE:     next_stage = FETCH_OPERATION;
      FETCH_OPERATION: next_stage = fetch_done ? DECODE : FETCH_OPERATION;
      DECODE:          next_stage = FETCH_OPERAND;
      FETCH_OPERAND:   next_stage = operand_done ? EXECUTE : FETCH_OPERAND;
      EXECUTE: begin
        if (decode_ope == HLT) begin
          next_stage = HALTED;
        end else if (decode_ope == JMP || decode_ope == NOP) begin
          next_stage = FETCH_OPERATION;
        end else if (decode_dst == ADDRESS_IMM) begin
          next_stage = WRITE_MEMORY;
        end else if (decode_dst == REG_A || decode_dst == REG_SP) begin
          next_stage = WRITE_REGISTER;
        end else begin
          next_stage = FETCH_OPERATION;
        end
      end
      WRITE_REGISTER:  next_stage = FETCH_OPERATION;
      WRITE_MEMORY:    next_stage = FETCH_OPERATION;
      // Only RESET leaves here
      HALTED:          next_stage = HALTED;
      default:         next_stage = RESET_STAGE;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      stage <= RESET_STAGE;
    end else begin
      stage <= next_stage;
    end
  end

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_unit (
  input    logic                        CLOCK
  , input  logic                        RESET
  , input  cpu_pkg::cpu_stage_t         stage
  , input  logic [`CPU_WORD_WIDTH-1:0]  read_bus
  , input  logic                        ip_step
  , input  cpu_pkg::opcode_t            decode_ope
  , input  logic [`CPU_WORD_WIDTH-1:0]  imm
  , output logic [`CPU_WORD_WIDTH-1:0]  fetch_addr
  , output logic [`CPU_WORD_WIDTH-1:0]  ope
  , output logic                        fetch_done
  , output logic                        fetch_read
);
  import cpu_pkg::*;

  fetch_phase_t               phase;
  logic [`CPU_WORD_WIDTH-1:0] ip;

  assign fetch_addr = ip;
  assign fetch_read = (stage == FETCH_OPERATION) && (phase == REQUEST);
  assign fetch_done = (stage == FETCH_OPERATION) && (phase == LOAD);

  // Armed at REQUEST while other stages run
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      phase <= IDLE;
    end else if (stage != FETCH_OPERATION) begin
      phase <= REQUEST;
    end else begin
      case (phase)
        REQUEST: phase <= LOAD;
        LOAD:    phase <= IDLE;
        default: phase <= REQUEST;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      ope <= `CPU_NOP_BYTE;
    end else if (fetch_done) begin
      ope <= read_bus;
    end
  end

  // ip already points past the offset byte when JMP executes
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      ip <= '0;
    end else if (fetch_done || ip_step) begin
      ip <= ip + `CPU_WORD_WIDTH'd1;
    end else if (stage == EXECUTE && decode_ope == JMP) begin
      ip <= ip + imm;
    end
  end

endmodule

/* design/instruction_decoder.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module instruction_decoder (
  input    logic                        CLOCK
  , input  logic                        RESET
  , input  cpu_pkg::cpu_stage_t         stage
  , input  logic [`CPU_WORD_WIDTH-1:0]  ope
  , output cpu_pkg::opcode_t            decode_ope
  , output cpu_pkg::operand_t           decode_src
  , output cpu_pkg::operand_t           decode_dst
);
  import cpu_pkg::*;

  logic [1:0] group_field;
  logic [1:0] op_field;
  logic [1:0] dst_field;
  logic [1:0] src_field;
  logic       fields_ok;
  operand_t   reg_dst;
  operand_t   reg_src;
  opcode_t    next_ope;
  operand_t   next_src;
  operand_t   next_dst;

  assign group_field = ope[`CPU_GROUP_BITS];
  assign op_field    = ope[`CPU_OP_BITS];
  assign dst_field   = ope[`CPU_DST_BITS];
  assign src_field   = ope[`CPU_SRC_BITS];

  assign fields_ok = (op_field inside {`CPU_OP_MOV, `CPU_OP_ADD})
                  && (dst_field inside {`CPU_MODE_REG, `CPU_MODE_MEM})
                  && (src_field inside {`CPU_MODE_REG, `CPU_MODE_MEM, `CPU_MODE_IMM});

  // Register pair named by the group
  always_comb begin
    reg_dst = UNUSED;
    reg_src = UNUSED;
    case (group_field)
      `CPU_GROUP_A_A: begin
        reg_dst = REG_A;
        reg_src = REG_A;
      end
      `CPU_GROUP_SP_SP: begin
        reg_dst = REG_SP;
        reg_src = REG_SP;
      end
      `CPU_GROUP_SP_A: begin
        reg_dst = REG_SP;
        reg_src = REG_A;
      end
      default: ;
    endcase
  end

  // Anything not matched falls through as HLT
  always_comb begin
    next_ope = HLT;
    next_src = UNUSED;
    next_dst = UNUSED;
    if (ope == `CPU_NOP_BYTE) begin
      next_ope = NOP;
    end else if (ope == `CPU_HLT_BYTE) begin
      next_ope = HLT;
    end else if (ope[`CPU_JMP_BITS] == `CPU_JMP_PREFIX) begin
      next_ope = JMP;
      next_src = IMM;
    end else if (reg_dst != UNUSED && fields_ok) begin
      next_ope = (op_field == `CPU_OP_ADD) ? ADD : MOV;
      next_dst = (dst_field == `CPU_MODE_MEM) ? ADDRESS_IMM : reg_dst;
      case (src_field)
        `CPU_MODE_MEM: next_src = ADDRESS_IMM;
        `CPU_MODE_IMM: next_src = IMM;
        default:       next_src = reg_src;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      decode_ope <= NOP;
      decode_src <= UNUSED;
      decode_dst <= UNUSED;
    end else if (stage == DECODE) begin
      decode_ope <= next_ope;
      decode_src <= next_src;
      decode_dst <= next_dst;
    end
  end

endmodule

/* design/operand_fetch.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module operand_fetch (
  input    logic                        CLOCK
  , input  logic                        RESET
  , input  cpu_pkg::cpu_stage_t         stage
  , input  logic [`CPU_WORD_WIDTH-1:0]  read_bus
  , input  logic [`CPU_WORD_WIDTH-1:0]  fetch_addr
  , input  cpu_pkg::operand_t           decode_src
  , input  cpu_pkg::operand_t           decode_dst
  , output logic [`CPU_WORD_WIDTH-1:0]  operand_addr
  , output logic [`CPU_WORD_WIDTH-1:0]  dst_addr
  , output logic [`CPU_WORD_WIDTH-1:0]  imm
  , output logic [`CPU_WORD_WIDTH-1:0]  mem_src
  , output logic [`CPU_WORD_WIDTH-1:0]  mem_dst
  , output logic                        ip_step
  , output logic                        operand_done
  , output logic                        operand_read
);
  import cpu_pkg::*;

  operand_phase_t             phase;
  operand_phase_t             next_phase;
  operand_phase_t             after_src;
  logic                       active;
  logic [`CPU_WORD_WIDTH-1:0] src_addr;

  assign active = (stage == FETCH_OPERAND);

  // Destination bytes follow whatever the source needed
  assign after_src = (decode_dst == ADDRESS_IMM) ? WAIT_DST_ADDR : DONE;

  always_comb begin
    case (phase)
      BEGIN: begin
        if (decode_src == IMM) begin
          next_phase = WAIT_IMM;
        end else if (decode_src == ADDRESS_IMM) begin
          next_phase = WAIT_SRC_ADDR;
        end else begin
          next_phase = after_src;
        end
      end
      WAIT_IMM:      next_phase = LOAD_IMM;
      LOAD_IMM:      next_phase = after_src;
      WAIT_SRC_ADDR: next_phase = LOAD_SRC_ADDR;
      LOAD_SRC_ADDR: next_phase = WAIT_SRC;
      WAIT_SRC:      next_phase = LOAD_SRC;
      LOAD_SRC:      next_phase = after_src;
      WAIT_DST_ADDR: next_phase = LOAD_DST_ADDR;
      LOAD_DST_ADDR: next_phase = WAIT_DST;
      WAIT_DST:      next_phase = LOAD_DST;
      LOAD_DST:      next_phase = DONE;
      default:       next_phase = BEGIN;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      phase <= BEGIN;
    end else if (active) begin
      phase <= next_phase;
    end else begin
      phase <= BEGIN;
    end
  end

  assign operand_done = active && (phase == DONE);
  assign operand_read = active
                     && (phase inside {WAIT_IMM, WAIT_SRC_ADDR, WAIT_SRC, WAIT_DST_ADDR, WAIT_DST});
  // Bytes taken from the instruction stream advance ip
  assign ip_step = active && (phase inside {LOAD_IMM, LOAD_SRC_ADDR, LOAD_DST_ADDR});

  always_comb begin
    case (phase)
      WAIT_SRC, LOAD_SRC: operand_addr = src_addr;
      WAIT_DST, LOAD_DST: operand_addr = dst_addr;
      default:            operand_addr = fetch_addr;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (active) begin
      case (phase)
        LOAD_IMM:      imm      <= read_bus;
        LOAD_SRC_ADDR: src_addr <= read_bus;
        LOAD_SRC:      mem_src  <= read_bus;
        LOAD_DST_ADDR: dst_addr <= read_bus;
        LOAD_DST:      mem_dst  <= read_bus;
        default: ;
      endcase
    end
  end

endmodule

/* design/execute_unit.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_unit (
  input    logic                        CLOCK
  , input  logic                        RESET
  , input  cpu_pkg::cpu_stage_t         stage
  , input  cpu_pkg::opcode_t            decode_ope
  , input  cpu_pkg::operand_t           decode_src
  , input  cpu_pkg::operand_t           decode_dst
  , input  logic [`CPU_WORD_WIDTH-1:0]  imm
  , input  logic [`CPU_WORD_WIDTH-1:0]  mem_src
  , input  logic [`CPU_WORD_WIDTH-1:0]  mem_dst
  , output logic [`CPU_WORD_WIDTH-1:0]  result
  , output logic [`CPU_WORD_WIDTH-1:0]  register_a
  , output logic [`CPU_WORD_WIDTH-1:0]  register_sp
);
  import cpu_pkg::*;

  logic [`CPU_WORD_WIDTH-1:0] src_value;
  logic [`CPU_WORD_WIDTH-1:0] dst_value;

  always_comb begin
    case (decode_src)
      REG_A:       src_value = register_a;
      REG_SP:      src_value = register_sp;
      ADDRESS_IMM: src_value = mem_src;
      IMM:         src_value = imm;
      default:     src_value = '0;
    endcase
  end

  // Original destination value for ADD
  always_comb begin
    case (decode_dst)
      REG_A:       dst_value = register_a;
      REG_SP:      dst_value = register_sp;
      ADDRESS_IMM: dst_value = mem_dst;
      default:     dst_value = '0;
    endcase
  end

  // Sum wraps at 8 bits
  always_ff @(posedge CLOCK) begin
    if (stage == EXECUTE) begin
      case (decode_ope)
        MOV:     result <= src_value;
        ADD:     result <= dst_value + src_value;
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      register_a  <= '0;
      register_sp <= '0;
    end else if (stage == WRITE_REGISTER) begin
      if (decode_dst == REG_A) begin
        register_a <= result;
      end
      if (decode_dst == REG_SP) begin
        register_sp <= result;
      end
    end
  end

endmodule

/* design/memory_port.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module memory_port (
  input    cpu_pkg::cpu_stage_t         stage
  , input  logic                        fetch_read
  , input  logic                        operand_read
  , input  logic [`CPU_WORD_WIDTH-1:0]  fetch_addr
  , input  logic [`CPU_WORD_WIDTH-1:0]  operand_addr
  , input  logic [`CPU_WORD_WIDTH-1:0]  dst_addr
  , input  logic [`CPU_WORD_WIDTH-1:0]  result
  , output logic [`CPU_WORD_WIDTH-1:0]  addr_bus
  , output cpu_pkg::mem_cmd_t           ctrl_bus
  , output logic [`CPU_WORD_WIDTH-1:0]  write_bus
);
  import cpu_pkg::*;

  always_comb begin
    if (stage == WRITE_MEMORY) begin
      ctrl_bus = MEMORY_WRITE;
      addr_bus = dst_addr;
    end else if (operand_read) begin
      ctrl_bus = MEMORY_READ;
      addr_bus = operand_addr;
    end else begin
      // Idle cycles leave the bus on ip
      ctrl_bus = fetch_read ? MEMORY_READ : MEMORY_STAY;
      addr_bus = fetch_addr;
    end
  end

  assign write_bus = result;

endmodule

/* design/cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top (
  input    logic                        CLOCK
  , input  logic                        RESET
  , input  logic [`CPU_WORD_WIDTH-1:0]  read_bus
  , output logic [`CPU_WORD_WIDTH-1:0]  addr_bus
  , output cpu_pkg::mem_cmd_t           ctrl_bus
  , output logic [`CPU_WORD_WIDTH-1:0]  write_bus
  , output logic [`CPU_WORD_WIDTH-1:0]  out
  , output logic                        halted
);
  import cpu_pkg::*;

  cpu_stage_t stage;

  logic                       fetch_done;
  logic                       fetch_read;
  logic [`CPU_WORD_WIDTH-1:0] fetch_addr;
  logic [`CPU_WORD_WIDTH-1:0] ope;

  opcode_t  decode_ope;
  operand_t decode_src;
  operand_t decode_dst;

  logic                       operand_done;
  logic                       operand_read;
  logic                       ip_step;
  logic [`CPU_WORD_WIDTH-1:0] operand_addr;
  logic [`CPU_WORD_WIDTH-1:0] dst_addr;
  logic [`CPU_WORD_WIDTH-1:0] imm;
  logic [`CPU_WORD_WIDTH-1:0] mem_src;
  logic [`CPU_WORD_WIDTH-1:0] mem_dst;

  logic [`CPU_WORD_WIDTH-1:0] result;
  logic [`CPU_WORD_WIDTH-1:0] register_a;
  logic [`CPU_WORD_WIDTH-1:0] register_sp;

  stage_control stage_control_inst (.*);

  fetch_unit fetch_unit_inst (.*);

  instruction_decoder instruction_decoder_inst (.*);

  operand_fetch operand_fetch_inst (.*);

  execute_unit execute_unit_inst (.*);

  memory_port memory_port_inst (.*);

  assign out    = register_a;
  assign halted = (stage == HALTED);

endmodule

/* tests/tb_memory.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_memory (
  input    logic                        CLOCK
  , input  logic [`CPU_WORD_WIDTH-1:0]  addr_bus
  , input  cpu_pkg::mem_cmd_t           ctrl_bus
  , input  logic [`CPU_WORD_WIDTH-1:0]  write_bus
  , output logic [`CPU_WORD_WIDTH-1:0]  read_bus
);
  import cpu_pkg::*;

  logic [`CPU_WORD_WIDTH-1:0] mem [256];
  logic [`CPU_WORD_WIDTH-1:0] read_data = 8'h00;

  assign read_bus = read_data;

  // Read data appears at the command edge and holds until the next read
  always @(posedge CLOCK) begin
    if (ctrl_bus == MEMORY_READ) begin
      read_data <= mem[addr_bus];
    end else if (ctrl_bus == MEMORY_WRITE) begin
      mem[addr_bus] <= write_bus;
    end
  end

  // Background pattern that differs in every cell
  task automatic fill_memory();
    int i;
    for (i = 0; i < 256; i++) begin
      mem[i] <= 8'(i) ^ 8'hA5;
    end
  endtask

  task automatic write_byte(input logic [`CPU_WORD_WIDTH-1:0] addr,
                            input logic [`CPU_WORD_WIDTH-1:0] data);
    mem[addr] <= data;
  endtask

  task automatic read_byte(input logic [`CPU_WORD_WIDTH-1:0] addr,
                           output logic [`CPU_WORD_WIDTH-1:0] data);
    data = mem[addr];
  endtask

endmodule

/* tests/tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu;
  import cpu_pkg::*;

  logic                       CLOCK;
  logic                       RESET;
  logic [`CPU_WORD_WIDTH-1:0] read_bus;
  logic [`CPU_WORD_WIDTH-1:0] addr_bus;
  mem_cmd_t                   ctrl_bus;
  logic [`CPU_WORD_WIDTH-1:0] write_bus;
  logic [`CPU_WORD_WIDTH-1:0] out;
  logic                       halted;

  // One record per data byte, A value or end marker
  logic [7:0]                 rec_tag[$];
  logic [`CPU_WORD_WIDTH-1:0] rec_addr[$];
  logic [`CPU_WORD_WIDTH-1:0] rec_data[$];
  logic [`CPU_WORD_WIDTH-1:0] line_vals[32];

  int errors;
  int blocks;
  int cycles;
  int cycle_limit;

  cpu_top cpu_top_inst (
    .CLOCK(CLOCK), .RESET(RESET), .read_bus(read_bus), .addr_bus(addr_bus),
    .ctrl_bus(ctrl_bus), .write_bus(write_bus), .out(out), .halted(halted)
  );

  tb_memory memory_inst (
    .CLOCK(CLOCK), .addr_bus(addr_bus), .ctrl_bus(ctrl_bus),
    .write_bus(write_bus), .read_bus(read_bus)
  );

  initial begin
    CLOCK = 1'b0;
    forever #20 CLOCK = ~CLOCK;
  end

  always @(posedge CLOCK) begin
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the CPU did not halt in time", cycles);
      $display("Verification failed");
      $finish;
    end else begin
      cycles <= cycles + 1;
    end
  end

  task automatic report_mismatch(input string name, input logic [7:0] got,
                                 input logic [7:0] expected);
    errors++;
    $display("ERROR %s expected 0x%h got 0x%h", name, expected, got);
  endtask

  // Hex fields after the tag letter
  task automatic parse_fields(input string line, output int count);
    int i;
    int c;
    int digit;
    int value;
    bit in_token;
    count = 0;
    value = 0;
    in_token = 1'b0;
    for (i = 1; i <= line.len(); i++) begin
      c = (i < line.len()) ? int'(line.getc(i)) : 32;
      digit = -1;
      // ASCII 0-9, A-F, a-f
      if (c >= 48 && c <= 57) begin
        digit = c - 48;
      end else if (c >= 65 && c <= 70) begin
        digit = c - 55;
      end else if (c >= 97 && c <= 102) begin
        digit = c - 87;
      end
      if (digit >= 0) begin
        value = value * 16 + digit;
        in_token = 1'b1;
      end else if (in_token) begin
        if (count < 32) begin
          line_vals[count] = value[7:0];
        end
        count++;
        value = 0;
        in_token = 1'b0;
      end
    end
  endtask

  task automatic read_test_file();
    int fd;
    int n;
    int k;
    int preload_bytes;
    string line;
    logic [7:0] tag;
    preload_bytes = 0;
    fd = $fopen("tests/cpu_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file tests/cpu_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          tag = line.getc(0);
          parse_fields(line, n);
          if (tag == "P" || tag == "M") begin
            // Address first, then consecutive bytes
            for (k = 1; k < n; k++) begin
              rec_tag.push_back(tag);
              rec_addr.push_back(8'(line_vals[0] + k - 1));
              rec_data.push_back(line_vals[k]);
            end
            if (tag == "P") begin
              preload_bytes += n - 1;
            end
          end else if (tag == "A" || tag == "E") begin
            rec_tag.push_back(tag);
            rec_addr.push_back(8'h00);
            rec_data.push_back(line_vals[0]);
            if (tag == "E") begin
              blocks++;
            end
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = 12 * preload_bytes + 50 * blocks;
  endtask

  task automatic run_block(inout int idx);
    logic [`CPU_WORD_WIDTH-1:0] expected_a;
    logic [`CPU_WORD_WIDTH-1:0] held_out;
    logic [`CPU_WORD_WIDTH-1:0] got;
    logic [`CPU_WORD_WIDTH-1:0] exp_addr[$];
    logic [`CPU_WORD_WIDTH-1:0] exp_data[$];
    int i;
    expected_a = 8'h00;
    @(posedge CLOCK);
    #2;
    RESET = 1'b1;
    memory_inst.fill_memory();
    while (idx < rec_tag.size() && rec_tag[idx] != "E") begin
      case (rec_tag[idx])
        "P": memory_inst.write_byte(rec_addr[idx], rec_data[idx]);
        "A": expected_a = rec_data[idx];
        default: begin
          exp_addr.push_back(rec_addr[idx]);
          exp_data.push_back(rec_data[idx]);
        end
      endcase
      idx++;
    end
    idx++;

    repeat (4) @(posedge CLOCK);
    #2;
    RESET = 1'b0;

    // First cycle out of reset
    @(negedge CLOCK);
    if (ctrl_bus !== MEMORY_STAY) report_mismatch("ctrl_bus", 8'(ctrl_bus), 8'(MEMORY_STAY));
    if (halted !== 1'b0) report_mismatch("halted", 8'(halted), 8'h00);
    if (out !== 8'h00) report_mismatch("out", out, 8'h00);

    while (halted !== 1'b1) begin
      @(negedge CLOCK);
    end
    held_out = out;
    if (out !== expected_a) report_mismatch("out", out, expected_a);

    // Halted state must not move
    repeat (20) begin
      @(negedge CLOCK);
      if (halted !== 1'b1) report_mismatch("halted", 8'(halted), 8'h01);
      if (ctrl_bus !== MEMORY_STAY) report_mismatch("ctrl_bus", 8'(ctrl_bus), 8'(MEMORY_STAY));
      if (out !== held_out) report_mismatch("out", out, held_out);
    end

    for (i = 0; i < exp_addr.size(); i++) begin
      memory_inst.read_byte(exp_addr[i], got);
      if (got !== exp_data[i]) begin
        report_mismatch($sformatf("mem[%h]", exp_addr[i]), got, exp_data[i]);
      end
    end
  endtask

  initial begin
    int idx;
    RESET = 1'b1;
    errors = 0;
    blocks = 0;
    cycle_limit = 0;
    read_test_file();
    if (blocks == 0) begin
      $display("No complete test block was found in tests/cpu_tests.txt");
      errors++;
    end
    idx = 0;
    while (idx < rec_tag.size()) begin
      run_block(idx);
    end
    $display("Blocks: %0d, errors: %0d", blocks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tests/cpu_tests.txt */
# P addr bytes  preload consecutive bytes from addr; A value  expected final A
# M addr bytes  expected memory from addr; E  end of block; all values hex
# Register and immediate MOV and ADD, SP stored and added back into A
P 00 03 F0 13 25 80 53 F7 10 48 80 12 80 FF
P 80 55
A 36
M 80 0C
E
# Memory sources and destinations, ADD into memory
P 00 02 90 12 91 08 A0 80 53 05 48 A1 18 92 1B 30 93 0A 91 A2 FF
P 90 7E 9C 11 40
P A0 EE EE EE
A 1A
M 90 7E 9C 2B 70
M A0 1A 1F 9C
E
# Forward JMP over a store and an ADD
P 00 03 42 C0 04 08 B0 13 01 13 10 08 B1 C0 01 08 FF
P B0 5A 00
A 52
M B0 5A 52
E
# NOP, then an immediate destination which halts
P 00 FE 03 77 0C 03 11 FF
P C0 33
A 77
M C0 33
E
# A starts from zero again, register-indirect source halts
P 00 13 09 01 FF
A 09
E
# First program again
P 00 03 F0 13 25 80 53 F7 10 48 80 12 80 FF
P 80 55
A 36
M 80 0C
E

/* project.f */
+incdir+design
design/cpu_pkg.sv
design/stage_control.sv
design/fetch_unit.sv
design/instruction_decoder.sv
design/operand_fetch.sv
design/execute_unit.sv
design/memory_port.sv
design/cpu_top.sv
tests/tb_memory.sv
tests/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! rm -rf obj_dir; then
  echo "Could not clean obj_dir"
  exit 1
fi

if ! verilator --binary --timing -f project.f --top-module tb_cpu -o tb_cpu; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" sim.log; then
  exit 0
else
  exit 1
fi
